// ==== isa_pkg.sv ====
// isa types: data word, register index, addressing modes, alu ops, flags, decoded instruction
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // modes 0 to 3 only
    typedef enum logic [1:0] {
        mode_reg,
        mode_defer,
        mode_autoinc,
        mode_autoinc_defer
    } addr_mode_t;

    typedef enum logic [3:0] {
        alu_pass_src, alu_clr, alu_com, alu_inc, alu_dec, alu_neg, alu_tst,
        alu_add, alu_sub, alu_cmp, alu_bit_test, alu_bic, alu_bis
    } alu_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } cc_t;

    typedef enum logic [1:0] {
        class_single,
        class_double,
        class_illegal
    } op_class_t;

    typedef struct packed {
        op_class_t  op_class;
        alu_op_t    alu_op;
        addr_mode_t src_mode;
        reg_idx_t   src_reg;
        addr_mode_t dst_mode;
        reg_idx_t   dst_reg;
        // low for tst, cmp and bit
        logic       writes_result;
    } decoded_t;

    localparam reg_idx_t PC_REG  = 3'd7;
    localparam word_t    BOOT_PC = 16'o001000;

endpackage

// ==== ctrl_pkg.sv ====
// micro-control types: sequencer states, datapath command struct, bus request struct
package ctrl_pkg;

    typedef enum logic [3:0] {
        boot, if_req, id, of_reg, of_mem, of_defer, ex, wb, halt
    } state_t;

    // operand the sequencer is working on
    typedef enum logic {
        sel_src,
        sel_dst
    } operand_sel_t;

    typedef enum logic [1:0] {
        addr_pc,
        addr_src,
        addr_dst,
        addr_adr
    } addr_sel_t;

    typedef struct packed {
        logic         load_ir;
        logic         pc_inc;
        logic         reg_to_opnd;
        operand_sel_t operand_sel;
        logic         reg_autoinc;
        logic         dbi_to_opnd;
        logic         opnd_to_adr;
        logic         alu_to_dst;
        logic         cc_load;
        logic         dst_to_reg;
        logic         set_boot_pc;
        addr_sel_t    addr_sel;
        // latch written back by dst_to_reg
        operand_sel_t wdata_sel;
    } dp_cmd_t;

    typedef struct packed {
        logic           rd;
        logic           wr;
        logic           ifetch;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } bus_req_t;

endpackage

// ==== instr_decode.sv ====
// instruction decoder for the word single- and double-operand groups
`timescale 1ns/1ps

module instr_decode (
    input  isa_pkg::word_t    ir,
    output isa_pkg::decoded_t decoded
);

    import isa_pkg::*;

    always_comb begin
        decoded.op_class      = class_double;
        decoded.alu_op        = alu_pass_src;
        decoded.src_mode      = addr_mode_t'(ir[10:9]);
        decoded.src_reg       = ir[8:6];
        decoded.dst_mode      = addr_mode_t'(ir[4:3]);
        decoded.dst_reg       = ir[2:0];
        decoded.writes_result = 1'b1;

        if (ir[15:9] == 7'b0000_101) begin
            // 0050dd to 0057dd, adc and sbc dropped
            decoded.op_class = class_single;
            case (ir[8:6])
                3'o0: decoded.alu_op = alu_clr;
                3'o1: decoded.alu_op = alu_com;
                3'o2: decoded.alu_op = alu_inc;
                3'o3: decoded.alu_op = alu_dec;
                3'o4: decoded.alu_op = alu_neg;
                3'o7: begin
                    decoded.alu_op        = alu_tst;
                    decoded.writes_result = 1'b0;
                end
                default: decoded.op_class = class_illegal;
            endcase
        end else begin
            // top digit selects the op, byte forms fall to default
            case (ir[15:12])
                4'o01: decoded.alu_op = alu_pass_src;
                4'o02: begin
                    decoded.alu_op        = alu_cmp;
                    decoded.writes_result = 1'b0;
                end
                4'o03: begin
                    decoded.alu_op        = alu_bit_test;
                    decoded.writes_result = 1'b0;
                end
                4'o04: decoded.alu_op = alu_bic;
                4'o05: decoded.alu_op = alu_bis;
                4'o06: decoded.alu_op = alu_add;
                4'o16: decoded.alu_op = alu_sub;
                default: decoded.op_class = class_illegal;
            endcase
            // source modes 4 to 7
            if (ir[11]) decoded.op_class = class_illegal;
        end

        // destination modes 4 to 7
        if (ir[5]) decoded.op_class = class_illegal;
    end

endmodule

// ==== control_fsm.sv ====
// instruction sequencer: boot, fetch, decode, operand fetch, execute, write-back, halt
`timescale 1ns/1ps

module control_fsm (
    input  logic              clk,
    input  logic              reset_n,
    input  isa_pkg::decoded_t decoded,
    input  logic              rd_done,
    input  logic              wr_done,
    output ctrl_pkg::dp_cmd_t dp_cmd,
    output logic              rd_strobe,
    output logic              wr_strobe,
    output logic              ifetch,
    output logic              halted
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    state_t       state;
    state_t       next;
    operand_sel_t opsrcdst_q;
    operand_sel_t opsrcdst_next;
    addr_mode_t   mode;
    addr_sel_t    opnd_addr;
    logic         opnd_done;

    // mode and address latch of the operand in progress
    assign mode      = (opsrcdst_q == sel_src) ? decoded.src_mode : decoded.dst_mode;
    assign opnd_addr = (opsrcdst_q == sel_src) ? addr_src : addr_dst;
    assign halted    = (state == halt);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= boot;
            opsrcdst_q <= sel_src;
        end else begin
            state      <= next;
            opsrcdst_q <= opsrcdst_next;
        end
    end

    // ========================================================================
    // next state and datapath strobes
    // ========================================================================
    always_comb begin
        next               = state;
        opsrcdst_next      = opsrcdst_q;
        dp_cmd             = '0;
        dp_cmd.operand_sel = opsrcdst_q;
        rd_strobe          = 1'b0;
        wr_strobe          = 1'b0;
        ifetch             = 1'b0;
        opnd_done          = 1'b0;

        case (state)
            boot: begin
                dp_cmd.set_boot_pc = 1'b1;
                next               = if_req;
            end
            if_req: begin
                rd_strobe       = 1'b1;
                ifetch          = 1'b1;
                dp_cmd.addr_sel = addr_pc;
                if (rd_done) begin
                    dp_cmd.load_ir = 1'b1;
                    dp_cmd.pc_inc  = 1'b1;
                    next           = id;
                end
            end
            id: begin
                // single-op goes straight to the destination
                case (decoded.op_class)
                    class_single: begin
                        opsrcdst_next = sel_dst;
                        next          = of_reg;
                    end
                    class_double: begin
                        opsrcdst_next = sel_src;
                        next          = of_reg;
                    end
                    default: next = halt;
                endcase
            end
            of_reg: begin
                // register value, or address for modes 1 to 3
                dp_cmd.reg_to_opnd = 1'b1;
                dp_cmd.reg_autoinc = (mode == mode_autoinc) || (mode == mode_autoinc_defer);
                if (mode == mode_reg) opnd_done = 1'b1;
                else next = of_mem;
            end
            of_mem, of_defer: begin
                rd_strobe       = 1'b1;
                dp_cmd.addr_sel = opnd_addr;
                if (rd_done) begin
                    dp_cmd.dbi_to_opnd = 1'b1;
                    dp_cmd.opnd_to_adr = 1'b1;
                    if (state == of_mem && mode == mode_autoinc_defer) next = of_defer;
                    else opnd_done = 1'b1;
                end
            end
            ex: begin
                dp_cmd.cc_load    = 1'b1;
                dp_cmd.alu_to_dst = decoded.writes_result;
                next              = decoded.writes_result ? wb : if_req;
            end
            wb: begin
                if (decoded.dst_mode == mode_reg) begin
                    dp_cmd.dst_to_reg = 1'b1;
                    dp_cmd.wdata_sel  = sel_dst;
                    next              = if_req;
                end else begin
                    wr_strobe       = 1'b1;
                    dp_cmd.addr_sel = addr_adr;
                    if (wr_done) next = if_req;
                end
            end
            // halt parks here until reset
            default: next = halt;
        endcase

        // source done, so on to the destination
        if (opnd_done) begin
            if (opsrcdst_q == sel_src) begin
                opsrcdst_next = sel_dst;
                next          = of_reg;
            end else begin
                next = ex;
            end
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state inside {boot, if_req, id, of_reg, of_mem, of_defer, ex, wb, halt});

    a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        !(rd_strobe && wr_strobe));

endmodule

// ==== register_file.sv ====
// general registers r0-r7, src/dst/adr operand latches, instruction register, bus address mux
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  ctrl_pkg::dp_cmd_t dp_cmd,
    input  isa_pkg::decoded_t decoded,
    input  isa_pkg::word_t    rdata,
    input  isa_pkg::word_t    result,
    output isa_pkg::word_t    src,
    output isa_pkg::word_t    dst,
    output isa_pkg::word_t    adr,
    output isa_pkg::word_t    pc,
    output isa_pkg::word_t    ir
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t    regs [8];
    word_t    src_q;
    word_t    dst_q;
    word_t    adr_q;
    word_t    ir_q;
    word_t    opnd_q;
    word_t    opnd_in;
    word_t    wb_data;
    reg_idx_t opnd_reg;
    logic     opnd_load;

    // operand side picks register and latch
    assign opnd_reg  = (dp_cmd.operand_sel == sel_src) ? decoded.src_reg : decoded.dst_reg;
    assign opnd_q    = (dp_cmd.operand_sel == sel_src) ? src_q : dst_q;
    assign opnd_in   = dp_cmd.reg_to_opnd ? regs[opnd_reg] : rdata;
    assign opnd_load = dp_cmd.reg_to_opnd | dp_cmd.dbi_to_opnd;
    assign wb_data   = (dp_cmd.wdata_sel == sel_dst) ? dst_q : src_q;

    // ========================================================================
    // registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (dp_cmd.set_boot_pc) regs[PC_REG] <= BOOT_PC;
        if (dp_cmd.pc_inc) regs[PC_REG] <= regs[PC_REG] + 16'd2;
        if (dp_cmd.reg_autoinc) regs[opnd_reg] <= regs[opnd_reg] + 16'd2;
        if (dp_cmd.dst_to_reg) regs[decoded.dst_reg] <= wb_data;
    end

    // latches; adr takes the address the operand came from
    always_ff @(posedge clk) begin
        if (opnd_load && dp_cmd.operand_sel == sel_src) src_q <= opnd_in;
        if (dp_cmd.alu_to_dst) dst_q <= result;
        else if (opnd_load && dp_cmd.operand_sel == sel_dst) dst_q <= opnd_in;
        if (dp_cmd.opnd_to_adr) adr_q <= opnd_q;
        if (dp_cmd.load_ir) ir_q <= rdata;
    end

    // bus address
    always_comb begin
        case (dp_cmd.addr_sel)
            addr_pc:  adr = regs[PC_REG];
            addr_src: adr = src_q;
            addr_dst: adr = dst_q;
            default:  adr = adr_q;
        endcase
    end

    assign src = src_q;
    assign dst = dst_q;
    assign pc  = regs[PC_REG];
    assign ir  = ir_q;

    // pc word aligned from the boot step on
    a_pc_even: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> !pc[0]);

endmodule

// ==== alu.sv ====
// 16-bit alu with n/z/v/c generation and the psw flags register
`timescale 1ns/1ps

module alu (
    input  logic             clk,
    input  logic             reset_n,
    input  isa_pkg::alu_op_t op,
    input  logic             cc_load,
    input  isa_pkg::word_t   src,
    input  isa_pkg::word_t   dst,
    output isa_pkg::word_t   result,
    output isa_pkg::cc_t     cc
);

    import isa_pkg::*;

    cc_t   cc_q;
    cc_t   cc_next;
    word_t res;

    // c kept unless the op defines it
    always_comb begin
        res       = dst;
        cc_next   = cc_q;
        cc_next.v = 1'b0;
        case (op)
            alu_pass_src: res = src;
            alu_clr: begin
                res       = '0;
                cc_next.c = 1'b0;
            end
            alu_com: begin
                res       = ~dst;
                cc_next.c = 1'b1;
            end
            alu_inc: begin
                res       = dst + 16'd1;
                cc_next.v = (dst == 16'h7fff);
            end
            alu_dec: begin
                res       = dst - 16'd1;
                cc_next.v = (dst == 16'h8000);
            end
            alu_neg: begin
                res       = -dst;
                cc_next.v = (dst == 16'h8000);
                cc_next.c = (dst != '0);
            end
            alu_tst: cc_next.c = 1'b0;
            alu_add: begin
                {cc_next.c, res} = {1'b0, src} + {1'b0, dst};
                cc_next.v        = (src[15] == dst[15]) && (res[15] != src[15]);
            end
            // dst - src, c is the borrow
            alu_sub: begin
                {cc_next.c, res} = {1'b0, dst} - {1'b0, src};
                cc_next.v        = (src[15] != dst[15]) && (res[15] == src[15]);
            end
            // src - dst, result only feeds the flags
            alu_cmp: begin
                {cc_next.c, res} = {1'b0, src} - {1'b0, dst};
                cc_next.v        = (src[15] != dst[15]) && (res[15] == dst[15]);
            end
            alu_bit_test: res = src & dst;
            alu_bic:      res = ~src & dst;
            alu_bis:      res = src | dst;
            default:      res = dst;
        endcase
        cc_next.n = res[15];
        cc_next.z = (res == '0);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) cc_q <= '0;
        else if (cc_load) cc_q <= cc_next;
    end

    assign result = res;
    assign cc     = cc_q;

endmodule

// ==== bus_port.sv ====
// bus request register and ready qualifier for reads and writes
`timescale 1ns/1ps

module bus_port (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               rd_strobe,
    input  logic               wr_strobe,
    input  logic               ifetch,
    input  isa_pkg::word_t     addr,
    input  isa_pkg::word_t     wdata,
    input  logic               ready,
    output ctrl_pkg::bus_req_t bus_req,
    output logic               rd_done,
    output logic               wr_done
);

    import ctrl_pkg::*;

    bus_req_t req_q;
    logic     active;
    logic     waited_q;
    logic     done;

    // ready only counts for a request already out last cycle
    assign active  = req_q.rd | req_q.wr;
    assign done    = active & waited_q & ready;
    assign rd_done = done & req_q.rd;
    assign wr_done = done & req_q.wr;
    assign bus_req = req_q;

    always_ff @(posedge clk) begin
        if (!reset_n || done) begin
            req_q.rd     <= 1'b0;
            req_q.wr     <= 1'b0;
            req_q.ifetch <= 1'b0;
            waited_q     <= 1'b0;
        end else if (!active && (rd_strobe || wr_strobe)) begin
            req_q.rd     <= rd_strobe;
            req_q.wr     <= wr_strobe;
            req_q.ifetch <= ifetch;
            req_q.addr   <= addr;
            req_q.wdata  <= wdata;
        end else begin
            waited_q <= active;
        end
    end

    // request frozen until answered
    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (active && !done) |=> $stable(bus_req));

endmodule

// ==== cpu_top.sv ====
// cpu top level: sequencer, decoder, register file, alu and bus port
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               ready,
    input  isa_pkg::word_t     rdata,
    output ctrl_pkg::bus_req_t bus_req,
    output isa_pkg::cc_t       cc,
    output logic               halted
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    decoded_t decoded;
    dp_cmd_t  dp_cmd;
    logic     rd_strobe;
    logic     wr_strobe;
    logic     ifetch;
    logic     rd_done;
    logic     wr_done;
    word_t    result;
    word_t    src;
    word_t    dst;
    word_t    adr;
    word_t    ir;

    control_fsm u_fsm (
        .clk       (clk),
        .reset_n   (reset_n),
        .decoded   (decoded),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .dp_cmd    (dp_cmd),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .ifetch    (ifetch),
        .halted    (halted)
    );

    instr_decode u_decode (
        .ir      (ir),
        .decoded (decoded)
    );

    // pc output left open, a debug view only
    register_file u_regs (
        .clk     (clk),
        .reset_n (reset_n),
        .dp_cmd  (dp_cmd),
        .decoded (decoded),
        .rdata   (rdata),
        .result  (result),
        .src     (src),
        .dst     (dst),
        .adr     (adr),
        .pc      (),
        .ir      (ir)
    );

    alu u_alu (
        .clk     (clk),
        .reset_n (reset_n),
        .op      (decoded.alu_op),
        .cc_load (dp_cmd.cc_load),
        .src     (src),
        .dst     (dst),
        .result  (result),
        .cc      (cc)
    );

    // write data is always the dst latch
    bus_port u_bus (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .ifetch    (ifetch),
        .addr      (adr),
        .wdata     (dst),
        .ready     (ready),
        .bus_req   (bus_req),
        .rd_done   (rd_done),
        .wr_done   (wr_done)
    );

endmodule

// ==== tb_memory.sv ====
// word memory model for the cpu bus with a per-request ready delay
`timescale 1ns/1ps

module tb_memory (
    input  logic               clk,
    input  ctrl_pkg::bus_req_t bus_req,
    input  logic [1:0]         delay_sel,
    output logic               ready,
    output isa_pkg::word_t     rdata
);

    import isa_pkg::*;

    localparam int DEPTH = 1024;

    word_t      words [DEPTH];
    logic [1:0] delay_edge;
    int         hold_cycles;
    int         waited;

    initial begin
        ready       = 1'b0;
        rdata       = '0;
        hold_cycles = 0;
        waited      = 0;
    end

    // odd multiplier, so every index bit changes the word
    task automatic fill_pattern();
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = word_t'(i * 40503) ^ 16'h5a5a;
        end
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        words[addr[10:1]] = data;
    endtask

    // delay picked from the value held before the edge
    always @(posedge clk) begin
        delay_edge = delay_sel;
        #1;
        ready = 1'b0;
        if (!(bus_req.rd || bus_req.wr)) begin
            waited = 0;
        end else if (waited == 0) begin
            // first request cycle, ready would not count yet
            hold_cycles = delay_edge;
            waited      = 1;
        end else if (waited > hold_cycles) begin
            ready = 1'b1;
            if (bus_req.wr) words[bus_req.addr[10:1]] = bus_req.wdata;
            else rdata = words[bus_req.addr[10:1]];
        end else begin
            waited++;
        end
    end

endmodule

// ==== tb_cpu.sv ====
// clock, reset, program image, reference flags, bus assertions, timeout and report for the cpu
`timescale 1ns/1ps

module tb_cpu;

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int    PROG_INSTRS = 15;
    localparam int    MAX_WRITES  = 8;
    localparam int    PASSES      = 2;
    localparam int    CYCLE_LIMIT = PASSES * 40 * PROG_INSTRS + 200;
    localparam word_t X0          = 16'h0400;
    localparam word_t X1          = 16'h0402;
    localparam word_t Y0          = 16'h0404;

    logic       clk;
    logic       reset_n;
    logic       ready;
    word_t      rdata;
    bus_req_t   bus_req;
    cc_t        cc;
    logic       halted;
    logic [1:0] delay_sel;
    logic       random_delay;
    logic       in_reset_q   = 1'b0;
    int         cycles       = 0;
    int         fetch_idx    = 0;
    int         wr_idx       = 0;
    int         num_wr       = 0;
    int         instr_count  = 0;
    int         value_errors = 0;
    int         other_errors = 0;
    word_t      build_pc;
    word_t      opa;
    word_t      opb;
    word_t      tst_val;
    word_t      vals [4];
    word_t      exp_addr [MAX_WRITES];
    word_t      exp_data [MAX_WRITES];
    cc_t        cc_exp [PROG_INSTRS + 1];
    logic       cc_chk [PROG_INSTRS + 1];
    word_t      exp_wr_addr;
    word_t      exp_wr_data;
    cc_t        exp_cc_now;
    logic       cc_check_now;

    cpu_top DUT (
        .clk     (clk),
        .reset_n (reset_n),
        .ready   (ready),
        .rdata   (rdata),
        .bus_req (bus_req),
        .cc      (cc),
        .halted  (halted)
    );

    tb_memory mem (
        .clk       (clk),
        .bus_req   (bus_req),
        .delay_sel (delay_sel),
        .ready     (ready),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // reference flags from the pdp-11 rules
    // ========================================================================
    function automatic cc_t add_flags(input word_t x, input word_t y);
        int    sum;
        word_t r;
        cc_t   f;
        sum = int'($signed(x)) + int'($signed(y));
        r   = x + y;
        f.n = r[15];
        f.z = (r == 16'd0);
        f.v = (sum > 32767) || (sum < -32768);
        f.c = (int'(x) + int'(y)) > 65535;
        return f;
    endfunction

    // minuend minus subtrahend with c as the borrow
    function automatic cc_t sub_flags(input word_t m, input word_t s);
        int    diff;
        word_t r;
        cc_t   f;
        diff = int'($signed(m)) - int'($signed(s));
        r    = m - s;
        f.n  = r[15];
        f.z  = (r == 16'd0);
        f.v  = (diff > 32767) || (diff < -32768);
        f.c  = (m < s);
        return f;
    endfunction

    function automatic cc_t word_flags(input word_t w, input logic c);
        cc_t f;
        f.n = w[15];
        f.z = (w == 16'd0);
        f.v = 1'b0;
        f.c = c;
        return f;
    endfunction

    // ========================================================================
    // program image
    // ========================================================================
    task automatic emit_instr(input word_t w);
        mem.load_word(build_pc, w);
        build_pc = build_pc + 16'd2;
        instr_count++;
    endtask

    task automatic emit_word(input word_t w);
        mem.load_word(build_pc, w);
        build_pc = build_pc + 16'd2;
    endtask

    task automatic expect_write(input word_t addr, input word_t data);
        exp_addr[num_wr] = addr;
        exp_data[num_wr] = data;
        num_wr++;
    endtask

    // flags seen at the fetch after the instruction just emitted
    task automatic expect_cc(input cc_t f);
        cc_exp[instr_count] = f;
        cc_chk[instr_count] = 1'b1;
    endtask

    task automatic build_program();
        build_pc    = BOOT_PC;
        instr_count = 0;
        num_wr      = 0;
        for (int i = 0; i <= PROG_INSTRS; i++) cc_chk[i] = 1'b0;
        mem.fill_pattern();
        for (int i = 0; i < 4; i++) mem.load_word(Y0 + 16'(2 * i), vals[i]);
        emit_instr(16'o012701);
        emit_word(opa);
        emit_instr(16'o062701);
        emit_word(opb);
        expect_cc(add_flags(opa, opb));
        emit_instr(16'o010137);
        emit_word(X0);
        expect_write(X0, opa + opb);
        emit_instr(16'o012701);
        emit_word(opa);
        emit_instr(16'o162701);
        emit_word(opb);
        expect_cc(sub_flags(opa, opb));
        emit_instr(16'o010137);
        emit_word(X1);
        expect_write(X1, opa - opb);
        // mode 1 through r2 and r3 and mode 3 through the pc
        emit_instr(16'o012702);
        emit_word(Y0);
        emit_instr(16'o005112);
        expect_cc(word_flags(~vals[0], 1'b1));
        expect_write(Y0, ~vals[0]);
        emit_instr(16'o005237);
        emit_word(Y0 + 16'd2);
        expect_write(Y0 + 16'd2, vals[1] + 16'd1);
        emit_instr(16'o012703);
        emit_word(Y0 + 16'd4);
        emit_instr(16'o005413);
        expect_write(Y0 + 16'd4, 16'd0 - vals[2]);
        emit_instr(16'o005037);
        emit_word(Y0 + 16'd6);
        expect_cc(word_flags(16'd0, 1'b0));
        expect_write(Y0 + 16'd6, 16'd0);
        emit_instr(16'o022727);
        emit_word(opa);
        emit_word(opb);
        expect_cc(sub_flags(opa, opb));
        emit_instr(16'o005727);
        emit_word(tst_val);
        expect_cc(word_flags(tst_val, 1'b0));
        // movb lies outside the kept set
        emit_instr(16'o110102);
    endtask

    // ========================================================================
    // bus bookkeeping and watchdog
    // ========================================================================
    always @(posedge clk) begin
        in_reset_q <= !reset_n;
        if (!reset_n) begin
            fetch_idx <= 0;
            wr_idx    <= 0;
        end else begin
            if (bus_req.rd && bus_req.ifetch && ready) fetch_idx <= fetch_idx + 1;
            if (bus_req.wr && ready) wr_idx <= wr_idx + 1;
        end
    end

    always_comb begin
        exp_wr_addr  = '0;
        exp_wr_data  = '0;
        exp_cc_now   = '0;
        cc_check_now = 1'b0;
        if (wr_idx < num_wr) begin
            exp_wr_addr = exp_addr[wr_idx];
            exp_wr_data = exp_data[wr_idx];
        end
        if (fetch_idx <= PROG_INSTRS) begin
            exp_cc_now   = cc_exp[fetch_idx];
            cc_check_now = cc_chk[fetch_idx];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: cpu did not halt within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    a_reset_quiet: assert property (@(posedge clk)
        (!reset_n && in_reset_q) |-> !(bus_req.rd || bus_req.wr || halted))
        else begin
            other_errors++;
            $display("bus request or halted active during reset at %0t", $time);
        end

    a_first_fetch: assert property (@(posedge clk)
        $rose(reset_n) |-> !bus_req.rd ##1 !bus_req.rd
            ##1 (bus_req.rd && bus_req.ifetch && bus_req.addr == BOOT_PC))
        else begin
            other_errors++;
            $display("no instruction fetch at the boot pc two cycles after reset, %0t", $time);
        end

    a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        ((bus_req.rd || bus_req.wr) && !ready) |=> $stable(bus_req))
        else begin
            other_errors++;
            $display("bus request changed before ready at %0t", $time);
        end

    a_wr_expected: assert property (@(posedge clk) disable iff (!reset_n)
        (bus_req.wr && ready) |-> (wr_idx < num_wr))
        else begin
            other_errors++;
            $display("unexpected write to %h at %0t", $sampled(bus_req.addr), $time);
        end

    a_wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (bus_req.wr && ready && wr_idx < num_wr) |-> (bus_req.addr == exp_wr_addr))
        else begin
            value_errors++;
            $display("Error %0t bus_req.addr expected %h actual %h", $time,
                     $sampled(exp_wr_addr), $sampled(bus_req.addr));
        end

    a_wr_data: assert property (@(posedge clk) disable iff (!reset_n)
        (bus_req.wr && ready && wr_idx < num_wr) |-> (bus_req.wdata == exp_wr_data))
        else begin
            value_errors++;
            $display("Error %0t bus_req.wdata expected %h actual %h", $time,
                     $sampled(exp_wr_data), $sampled(bus_req.wdata));
        end

    a_cc: assert property (@(posedge clk) disable iff (!reset_n)
        ($rose(bus_req.rd && bus_req.ifetch) && cc_check_now) |-> (cc == exp_cc_now))
        else begin
            value_errors++;
            $display("Error %0t cc expected %b actual %b", $time,
                     $sampled(exp_cc_now), $sampled(cc));
        end

    a_halt_point: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(halted) |-> (fetch_idx == PROG_INSTRS && wr_idx == num_wr))
        else begin
            other_errors++;
            $display("halted after %0d fetches and %0d writes at %0t",
                     $sampled(fetch_idx), $sampled(wr_idx), $time);
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        halted |-> !(bus_req.rd || bus_req.wr))
        else begin
            other_errors++;
            $display("bus request while halted at %0t", $time);
        end

    // ========================================================================
    // stimulus with a zero-delay pass and then random ready delay
    // ========================================================================
    initial begin
        reset_n      = 1'b0;
        delay_sel    = 2'd0;
        random_delay = 1'b0;
        void'($urandom(77));
        opa     = word_t'($urandom());
        opb     = word_t'($urandom());
        tst_val = word_t'($urandom());
        for (int i = 0; i < 4; i++) vals[i] = word_t'($urandom());
        for (int pass = 0; pass < PASSES; pass++) begin
            random_delay = (pass == 1);
            reset_n      = 1'b0;
            build_program();
            repeat (16) @(posedge clk);
            #1 reset_n = 1'b1;
            while (!halted) begin
                @(posedge clk);
                #1;
                delay_sel = random_delay ? 2'($urandom % 4) : 2'd0;
            end
            // bus stays quiet after the halt
            repeat (20) @(posedge clk);
            #1;
        end
        $display("run complete: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
isa_pkg.sv
ctrl_pkg.sv
instr_decode.sv
control_fsm.sv
register_file.sv
alu.sv
bus_port.sv
cpu_top.sv
tb_memory.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: pdp11_lite

sources:
  - files:
      - isa_pkg.sv
      - ctrl_pkg.sv
      - instr_decode.sv
      - control_fsm.sv
      - register_file.sv
      - alu.sv
      - bus_port.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_memory.sv
      - tb_cpu.sv
